// File: flist.f
disp_cfg_pkg.sv
disp_glyph_pkg.sv
disp_scan_if.sv
scan_timebase.sv
status_lamps.sv
wait_animation.sv
digit_mux.sv
segment_decoder.sv
bubble_status_display.sv
bubble_status_display_props.sv
tb_bubble_status_display.sv

// File: Bender.yml
package:
  name: bubble_status_display

sources:
  - disp_cfg_pkg.sv
  - disp_glyph_pkg.sv
  - disp_scan_if.sv
  - scan_timebase.sv
  - status_lamps.sv
  - wait_animation.sv
  - digit_mux.sv
  - segment_decoder.sv
  - bubble_status_display.sv
  - target: test
    files:
      - bubble_status_display_props.sv
      - tb_bubble_status_display.sv

// File: tb_bubble_status_display.sv
`timescale 1ns/1ps

module tb_bubble_status_display;
    import disp_cfg_pkg::*;

    localparam int SCAN_DIV_BITS  = 2;
    localparam int ANIM_STEP_BITS = 6;
    localparam int CLK_PERIOD     = 10;
    localparam int SCAN_CYCLES    = 2 ** SCAN_DIV_BITS;
    localparam int ANIM_CYCLES    = 2 ** ANIM_STEP_BITS;
    // Rough length of all tests in cycles
    localparam int RUN_CYCLES     = 40 + 8 * SCAN_CYCLES + 20 * 9 * SCAN_CYCLES
                                  + (ANIM_FRAMES + 3) * 2 * ANIM_CYCLES;

    logic        MCLK;
    logic        arst_n;
    logic        nWAIT;
    logic [2:0]  ACCTYPE;
    logic [11:0] CURRPAGE;
    logic        nACCLED;
    logic        nWAITLED;
    logic        nREADLED;
    logic        nWRITELED;
    logic [7:0]  nFND;
    logic [2:0]  nANODE;

    logic [15:0] lfsr_state;
    int          check_count;
    int          error_count;

    bubble_status_display #(
        .SCAN_DIV_BITS  (SCAN_DIV_BITS),
        .ANIM_STEP_BITS (ANIM_STEP_BITS)
    ) u_dut (
        .MCLK      (MCLK),
        .arst_n    (arst_n),
        .nWAIT     (nWAIT),
        .ACCTYPE   (ACCTYPE),
        .CURRPAGE  (CURRPAGE),
        .nACCLED   (nACCLED),
        .nWAITLED  (nWAITLED),
        .nREADLED  (nREADLED),
        .nWRITELED (nWRITELED),
        .nFND      (nFND),
        .nANODE    (nANODE)
    );

    always #(CLK_PERIOD / 2) MCLK = ~MCLK;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Segments a..g, dp with a in bit 7
    function automatic logic [7:0] seg_ref(input logic [4:0] code);
        case (code)
            5'h00: seg_ref = 8'hFC;
            5'h01: seg_ref = 8'h60;
            5'h02: seg_ref = 8'hDA;
            5'h03: seg_ref = 8'hF2;
            5'h04: seg_ref = 8'h66;
            5'h05: seg_ref = 8'hB6;
            5'h06: seg_ref = 8'hBE;
            5'h07: seg_ref = 8'hE4;
            5'h08: seg_ref = 8'hFE;
            5'h09: seg_ref = 8'hF6;
            5'h0A: seg_ref = 8'hEE;
            5'h0B: seg_ref = 8'h3E;
            5'h0C: seg_ref = 8'h9C;
            5'h0D: seg_ref = 8'h7A;
            5'h0E: seg_ref = 8'h9E;
            5'h0F: seg_ref = 8'h8E;
            5'h10: seg_ref = 8'h80;
            5'h11: seg_ref = 8'h40;
            5'h12: seg_ref = 8'h20;
            5'h13: seg_ref = 8'h10;
            5'h14: seg_ref = 8'h08;
            5'h15: seg_ref = 8'h04;
            5'h16: seg_ref = 8'h02;
            5'h1F: seg_ref = 8'h01;
            default: seg_ref = 8'h00;
        endcase
    endfunction

    function automatic logic [11:0] anim_frame(input int f);
        case (f)
            0: anim_frame = 12'h077;
            1: anim_frame = 12'h607;
            2: anim_frame = 12'h670;
            3: anim_frame = 12'h671;
            4: anim_frame = 12'h762;
            5: anim_frame = 12'h763;
            6: anim_frame = 12'h736;
            7: anim_frame = 12'h376;
            8: anim_frame = 12'h476;
            9: anim_frame = 12'h576;
            default: anim_frame = 12'h777;
        endcase
    endfunction

    function automatic logic [23:0] digits_segs(input logic special, input logic [11:0] n);
        digits_segs = {seg_ref({special, n[11:8]}), seg_ref({special, n[7:4]}),
                       seg_ref({special, n[3:0]})};
    endfunction

    function automatic logic [3:0] page_nibble(input logic [2:0] anode, input logic [11:0] p);
        case (anode)
            3'b011: page_nibble = p[11:8];
            3'b101: page_nibble = p[7:4];
            default: page_nibble = p[3:0];
        endcase
    endfunction

    function automatic logic [2:0] next_anode(input logic [2:0] anode);
        case (anode)
            3'b011: next_anode = 3'b101;
            3'b101: next_anode = 3'b110;
            3'b110: next_anode = 3'b011;
            default: next_anode = 3'bxxx;
        endcase
    endfunction

    task automatic draw_page(output logic [11:0] page);
        int i;
        for (i = 0; i < 12; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            page = {page[10:0], lfsr_state[0]};
        end
    endtask

    task automatic compare_values(input string tname, input logic [31:0] expected,
                                  input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s: expected %h, actual %h", tname, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string tname, input int errs_before);
        $display("%-10s finished, %0d errors", tname, error_count - errs_before);
    endtask

    task automatic wait_anode(input logic [2:0] target);
        int n;
        n = 0;
        @(negedge MCLK);
        while (nANODE !== target && n < 4 * SCAN_CYCLES)
        begin
            @(negedge MCLK);
            n++;
        end
        if (nANODE !== target)
        begin
            $display("Anode never reached pattern %b", target);
            error_count++;
        end
    endtask

    // Digit 0 segments in the top byte
    task automatic capture_digits(output logic [23:0] segs);
        wait_anode(ANODE_D0);
        segs[23:16] = nFND;
        wait_anode(ANODE_D1);
        segs[15:8] = nFND;
        wait_anode(ANODE_D2);
        segs[7:0] = nFND;
    endtask

    // Two equal captures in a row rule out a frame change mid-capture
    task automatic stable_frame(output logic [23:0] segs);
        logic [23:0] again;
        int n;
        capture_digits(segs);
        capture_digits(again);
        n = 0;
        while (again !== segs && n < 4)
        begin
            segs = again;
            capture_digits(again);
            n++;
        end
    endtask

    task automatic reset_values();
        int errs;
        errs = error_count;
        arst_n = 1'b0;
        repeat (2) @(negedge MCLK);
        compare_values("reset", 3'b011, nANODE);
        compare_values("reset", 4'hF, {nACCLED, nWAITLED, nREADLED, nWRITELED});
        compare_values("reset", seg_ref({1'b0, CURRPAGE[11:8]}), nFND);
        arst_n = 1'b1;
        report_test("reset", errs);
    endtask

    task automatic lamp_decode();
        logic [3:0] prev;
        logic [3:0] expected;
        int errs;
        int wi;
        int t;
        errs = error_count;
        prev = 4'hF;
        @(negedge MCLK);
        for (wi = 0; wi < 2; wi++)
        begin
            for (t = 0; t < 8; t++)
            begin
                nWAIT = ~wi[0];
                ACCTYPE = t[2:0];
                expected = {~ACCTYPE[2], nWAIT, ~ACCTYPE[1], ACCTYPE != 3'b101};
                @(negedge MCLK);
                compare_values("lamps", prev, {nACCLED, nWAITLED, nREADLED, nWRITELED});
                @(negedge MCLK);
                compare_values("lamps", expected, {nACCLED, nWAITLED, nREADLED, nWRITELED});
                prev = expected;
            end
        end
        nWAIT = 1'b1;
        ACCTYPE = 3'b000;
        repeat (3) @(negedge MCLK);
        report_test("lamps", errs);
    endtask

    task automatic anode_rotation();
        logic [2:0] cur;
        int errs;
        int hold;
        int k;
        errs = error_count;
        @(negedge MCLK);
        cur = nANODE;
        hold = 0;
        while (nANODE === cur && hold < 2 * SCAN_CYCLES)
        begin
            @(negedge MCLK);
            hold++;
        end
        for (k = 0; k < 6; k++)
        begin
            cur = nANODE;
            hold = 0;
            while (nANODE === cur && hold < 2 * SCAN_CYCLES)
            begin
                @(negedge MCLK);
                hold++;
            end
            compare_values("rotation", SCAN_CYCLES, hold);
            compare_values("rotation", next_anode(cur), nANODE);
        end
        report_test("rotation", errs);
    endtask

    task automatic page_display();
        logic [11:0] page;
        logic [23:0] segs;
        int errs;
        int i;
        errs = error_count;
        for (i = 0; i < 20; i++)
        begin
            draw_page(page);
            @(negedge MCLK);
            CURRPAGE = page;
            capture_digits(segs);
            compare_values("page", digits_segs(1'b0, page), segs);
        end
        report_test("page", errs);
    endtask

    task automatic animation_sequence();
        logic [23:0] prev;
        logic [23:0] cur;
        int errs;
        int start;
        int idx;
        int f;
        int k;
        int n;
        errs = error_count;
        @(negedge MCLK);
        nWAIT = 1'b0;
        repeat (3) @(negedge MCLK);
        stable_frame(cur);
        start = -1;
        for (f = 0; f < ANIM_FRAMES; f++)
            if (cur === digits_segs(1'b1, anim_frame(f)))
                start = f;
        if (start < 0)
        begin
            $display("Waiting display %h matches no animation frame", cur);
            error_count++;
        end
        else
        begin
            idx = start;
            // One lap plus one frame to see the wrap
            for (k = 0; k <= ANIM_FRAMES; k++)
            begin
                prev = cur;
                n = 0;
                while (cur === prev && n < 8)
                begin
                    stable_frame(cur);
                    n++;
                end
                idx = (idx + 1) % ANIM_FRAMES;
                compare_values("animation", digits_segs(1'b1, anim_frame(idx)), cur);
            end
        end
        report_test("animation", errs);
    endtask

    task automatic return_from_wait();
        logic [11:0] page;
        logic [23:0] segs;
        int errs;
        int n;
        errs = error_count;
        draw_page(page);
        @(negedge MCLK);
        CURRPAGE = page;
        nWAIT = 1'b1;
        n = 0;
        do
        begin
            @(negedge MCLK);
            n++;
        end
        while (nFND !== seg_ref({1'b0, page_nibble(nANODE, page)}) && n < 3);
        if (nFND !== seg_ref({1'b0, page_nibble(nANODE, page)}))
        begin
            $display("Page display did not come back within three cycles");
            error_count++;
        end
        compare_values("return", 1'b1, nWAITLED);
        capture_digits(segs);
        compare_values("return", digits_segs(1'b0, page), segs);
        report_test("return", errs);
    endtask

    initial
    begin
        logic [11:0] first_page;
        MCLK = 1'b0;
        arst_n = 1'b0;
        nWAIT = 1'b1;
        ACCTYPE = 3'b000;
        check_count = 0;
        error_count = 0;
        lfsr_state = 16'd9778;
        draw_page(first_page);
        CURRPAGE = first_page;
        reset_values();
        lamp_decode();
        anode_rotation();
        page_display();
        animation_sequence();
        return_from_wait();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("Timeout, the tests did not finish in time");
        $display("Errors found");
        $finish;
    end

endmodule

// File: bubble_status_display_props.sv
`timescale 1ns/1ps

module bubble_status_display_props (
    input logic       MCLK,
    input logic       arst_n,
    input logic [2:0] nANODE,
    input logic       scan_tick,
    input logic       nACCLED,
    input logic       nWRITELED
);

    // Exactly one digit enabled
    property one_cold_anode;
        @(posedge MCLK) disable iff (!arst_n)
        $countones(nANODE) == 2;
    endproperty

    // Anode moves only on the edge after a scan tick
    property anode_moves_on_tick;
        @(posedge MCLK) disable iff (!arst_n)
        (nANODE != $past(nANODE)) |-> $past(scan_tick);
    endproperty

    // Type 101 has bit 2 set
    property write_implies_access;
        @(posedge MCLK) disable iff (!arst_n)
        !nWRITELED |-> !nACCLED;
    endproperty

    a_one_cold: assert property (one_cold_anode)
        else $error("nANODE is not one-cold: %b", nANODE);

    a_anode_tick: assert property (anode_moves_on_tick)
        else $error("nANODE changed without a scan tick");

    a_write_access: assert property (write_implies_access)
        else $error("nWRITELED lit while nACCLED is dark");

endmodule

bind bubble_status_display bubble_status_display_props u_props (
    .MCLK      (MCLK),
    .arst_n    (arst_n),
    .nANODE    (nANODE),
    .scan_tick (scan.scan_tick),
    .nACCLED   (nACCLED),
    .nWRITELED (nWRITELED)
);

// File: bubble_status_display.sv
`timescale 1ns/1ps

module bubble_status_display #(
    parameter int SCAN_DIV_BITS  = disp_cfg_pkg::SCAN_DIV_BITS_DEF,
    parameter int ANIM_STEP_BITS = disp_cfg_pkg::ANIM_STEP_BITS_DEF
) (
    input  logic        MCLK,
    input  logic        arst_n,

    // From the emulator core
    input  logic        nWAIT,
    input  logic [2:0]  ACCTYPE,
    input  logic [11:0] CURRPAGE,

    // Front panel lamps, active low
    output logic        nACCLED,
    output logic        nWAITLED,
    output logic        nREADLED,
    output logic        nWRITELED,

    // Segments high for lit, a in bit 7
    output logic [7:0]  nFND,
    output logic [2:0]  nANODE
);
    import disp_glyph_pkg::*;

    disp_scan_if scan ();

    logic [11:0] pattern;
    glyph_t      glyph;
    seg_t        seg;

    scan_timebase #(
        .SCAN_DIV_BITS  (SCAN_DIV_BITS),
        .ANIM_STEP_BITS (ANIM_STEP_BITS)
    ) u_timebase (
        .MCLK   (MCLK),
        .arst_n (arst_n),
        .scan   (scan.timebase)
    );

    status_lamps u_lamps (
        .MCLK        (MCLK),
        .arst_n      (arst_n),
        .wait_n      (nWAIT),
        .acc_type    (ACCTYPE),
        .scan        (scan.lamps),
        .acc_led_n   (nACCLED),
        .wait_led_n  (nWAITLED),
        .read_led_n  (nREADLED),
        .write_led_n (nWRITELED)
    );

    wait_animation u_anim (
        .MCLK    (MCLK),
        .arst_n  (arst_n),
        .scan    (scan.anim),
        .pattern (pattern)
    );

    // Page is quasi-static, taken without a synchronizer
    digit_mux u_mux (
        .scan    (scan.mux),
        .page    (CURRPAGE),
        .pattern (pattern),
        .glyph   (glyph)
    );

    segment_decoder u_decoder (
        .glyph (glyph),
        .seg   (seg)
    );

    assign nFND   = seg;
    assign nANODE = scan.anode_sel;

endmodule

// File: segment_decoder.sv
`timescale 1ns/1ps

module segment_decoder (
    input  disp_glyph_pkg::glyph_t  glyph,
    output disp_glyph_pkg::seg_t    seg
);
    import disp_glyph_pkg::*;

    seg_t hex_seg;
    seg_t special_seg;

    // Hex shapes, lowercase b and d
    always_comb
    begin
        case (glyph.hex.digit)
            4'h0: hex_seg = 8'hFC;
            4'h1: hex_seg = 8'h60;
            4'h2: hex_seg = 8'hDA;
            4'h3: hex_seg = 8'hF2;
            4'h4: hex_seg = 8'h66;
            4'h5: hex_seg = 8'hB6;
            4'h6: hex_seg = 8'hBE;
            4'h7: hex_seg = 8'hE4;
            4'h8: hex_seg = 8'hFE;
            4'h9: hex_seg = 8'hF6;
            4'hA: hex_seg = 8'hEE;
            4'hB: hex_seg = 8'h3E;
            4'hC: hex_seg = 8'h9C;
            4'hD: hex_seg = 8'h7A;
            4'hE: hex_seg = 8'h9E;
            default: hex_seg = 8'h8E;
        endcase
    end

    // Single segment a..g, blank range, or dp only
    always_comb
    begin
        if (glyph.code == GLYPH_DP)
        begin
            special_seg = SEG_DP;
        end
        else if (glyph.code >= GLYPH_SEG_A && glyph.code < GLYPH_BLANK)
        begin
            special_seg = SEG_A >> glyph.code[2:0];
        end
        else
        begin
            special_seg = SEG_NONE;
        end
    end

    assign seg = glyph.hex.special ? special_seg : hex_seg;

endmodule

// File: digit_mux.sv
`timescale 1ns/1ps

module digit_mux (
    disp_scan_if.mux                scan,
    input  logic [11:0]             page,
    input  logic [11:0]             pattern,
    output disp_glyph_pkg::glyph_t  glyph
);
    import disp_cfg_pkg::*;
    import disp_glyph_pkg::*;

    logic [11:0] src;

    assign src = scan.waiting ? pattern : page;

    always_comb
    begin
        glyph.hex.special = scan.waiting;
        case (scan.anode_sel)
            ANODE_D0:
                glyph.hex.digit = src[11:8];
            ANODE_D1:
                glyph.hex.digit = src[7:4];
            ANODE_D2:
                glyph.hex.digit = src[3:0];
            default:
                glyph.code = GLYPH_BLANK;
        endcase
    end

endmodule

// File: wait_animation.sv
`timescale 1ns/1ps

module wait_animation (
    input  logic        MCLK,
    input  logic        arst_n,
    disp_scan_if.anim   scan,
    output logic [11:0] pattern
);
    import disp_cfg_pkg::*;

    localparam logic [3:0] LAST_FRAME = 4'(ANIM_FRAMES - 1);

    logic [3:0] frame;

    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            frame <= 4'd0;
        end
        else if (scan.anim_tick)
        begin
            if (frame == LAST_FRAME)
                frame <= 4'd0;
            else
                frame <= frame + 4'd1;
        end
    end

    // Segment index per digit, 7 is blank, digit 0 in the high nibble
    always_ff @(posedge MCLK)
    begin
        case (frame)
            4'd0:    pattern <= {4'h0, 4'h7, 4'h7};
            4'd1:    pattern <= {4'h6, 4'h0, 4'h7};
            4'd2:    pattern <= {4'h6, 4'h7, 4'h0};
            4'd3:    pattern <= {4'h6, 4'h7, 4'h1};
            4'd4:    pattern <= {4'h7, 4'h6, 4'h2};
            4'd5:    pattern <= {4'h7, 4'h6, 4'h3};
            4'd6:    pattern <= {4'h7, 4'h3, 4'h6};
            4'd7:    pattern <= {4'h3, 4'h7, 4'h6};
            4'd8:    pattern <= {4'h4, 4'h7, 4'h6};
            4'd9:    pattern <= {4'h5, 4'h7, 4'h6};
            default: pattern <= {4'h7, 4'h7, 4'h7};
        endcase
    end

endmodule

// File: status_lamps.sv
`timescale 1ns/1ps

module status_lamps (
    input  logic                MCLK,
    input  logic                arst_n,
    input  logic                wait_n,
    input  disp_cfg_pkg::acc_t  acc_type,
    disp_scan_if.lamps          scan,
    output logic                acc_led_n,
    output logic                wait_led_n,
    output logic                read_led_n,
    output logic                write_led_n
);
    import disp_cfg_pkg::*;

    logic wait_meta;
    logic wait_sync;
    acc_t acc_meta;
    acc_t acc_sync;

    // Two-flop synchronizers from the emulator core
    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wait_meta <= 1'b1;
            wait_sync <= 1'b1;
            acc_meta  <= ACC_IDLE;
            acc_sync  <= ACC_IDLE;
        end
        else
        begin
            wait_meta <= wait_n;
            wait_sync <= wait_meta;
            acc_meta  <= acc_type;
            acc_sync  <= acc_meta;
        end
    end

    // Lamps are active low
    assign acc_led_n   = ~acc_sync[2];
    assign read_led_n  = ~acc_sync[1];
    assign write_led_n = ~(acc_sync == ACC_WRITE);
    assign wait_led_n  = wait_sync;

    assign scan.waiting = ~wait_sync;

endmodule

// File: scan_timebase.sv
`timescale 1ns/1ps

module scan_timebase #(
    parameter int SCAN_DIV_BITS  = disp_cfg_pkg::SCAN_DIV_BITS_DEF,
    parameter int ANIM_STEP_BITS = disp_cfg_pkg::ANIM_STEP_BITS_DEF
) (
    input logic             MCLK,
    input logic             arst_n,
    disp_scan_if.timebase   scan
);
    import disp_cfg_pkg::*;

    logic [ANIM_STEP_BITS-1:0] div_cnt;
    anode_t                    anode_q;

    // Free running, wraps at full width
    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign scan.scan_tick = &div_cnt[SCAN_DIV_BITS-1:0];
    assign scan.anim_tick = &div_cnt;

    // Rotate right: 011 -> 101 -> 110 -> 011
    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            anode_q <= ANODE_D0;
        end
        else if (scan.scan_tick)
        begin
            anode_q <= {anode_q[0], anode_q[2:1]};
        end
    end

    assign scan.anode_sel = anode_q;

endmodule

// File: disp_scan_if.sv
`timescale 1ns/1ps

interface disp_scan_if;
    import disp_cfg_pkg::*;

    logic   scan_tick;
    logic   anim_tick;
    anode_t anode_sel;
    logic   waiting;

    modport timebase (
        output scan_tick,
        output anim_tick,
        output anode_sel
    );

    modport lamps (
        output waiting
    );

    modport anim (
        input anim_tick
    );

    modport mux (
        input anode_sel,
        input waiting
    );

endinterface

// File: disp_glyph_pkg.sv
package disp_glyph_pkg;

    // Hex reading of a glyph word
    typedef struct packed {
        logic       special;
        logic [3:0] digit;
    } glyph_hex_t;

    // One glyph word per digit, read as hex or as a special code
    typedef union packed {
        glyph_hex_t hex;
        logic [4:0] code;
    } glyph_t;

    // Special codes
    // 10h..16h light one of segments a..g
    // 17h..1Eh blank, 1Fh decimal point only
    localparam logic [4:0] GLYPH_SEG_A = 5'h10;
    localparam logic [4:0] GLYPH_BLANK = 5'h17;
    localparam logic [4:0] GLYPH_DP    = 5'h1F;

    // Segment vector a b c d e f g dp, a in bit 7, high is lit
    typedef logic [7:0] seg_t;

    localparam seg_t SEG_NONE = 8'h00;
    localparam seg_t SEG_A    = 8'h80;
    localparam seg_t SEG_DP   = 8'h01;

endpackage

// File: disp_cfg_pkg.sv
package disp_cfg_pkg;

    // Scan rate defaults for a 48 MHz MCLK
    localparam int SCAN_DIV_BITS_DEF  = 10;
    localparam int ANIM_STEP_BITS_DEF = 24;

    // One-cold anode select, digit 0 is the leftmost
    typedef logic [2:0] anode_t;

    localparam anode_t ANODE_D0 = 3'b011;
    localparam anode_t ANODE_D1 = 3'b101;
    localparam anode_t ANODE_D2 = 3'b110;

    // Frames in the waiting animation loop
    localparam int ANIM_FRAMES = 11;

    // Emulator access type
    typedef logic [2:0] acc_t;

    localparam acc_t ACC_IDLE  = 3'b000;
    localparam acc_t ACC_WRITE = 3'b101;

endpackage
